//--- design/box_consts.svh
`ifndef BOX_CONSTS_SVH
`define BOX_CONSTS_SVH

// Frame geometry
`define BOX_COLS 20
`define BOX_ROWS 16

// Window is square, centre at index BOX_WIN/2
`define BOX_WIN  13
`define BOX_AREA 169

// APB register map
`define BOX_ADDR_CTRL   12'h000
`define BOX_ADDR_THRESH 12'h004
`define BOX_ADDR_STATUS 12'h008

`endif

//--- design/box_pkg.sv
`include "box_consts.svh"

package box_pkg;

    // One column of vertically adjacent pixels, pix[6] is the centre row
    typedef struct packed {
        logic                       valid;
        logic [`BOX_WIN-1:0][7:0]   pix;
    } col_t;

    // Column sum with the centre pixel of the same column
    typedef struct packed {
        logic        valid;
        logic [11:0] sum;
        logic [7:0]  centre;
    } colsum_t;

    // Full window sum and the centre pixel aligned to it
    typedef struct packed {
        logic        valid;
        logic [15:0] sum;
        logic [7:0]  centre;
        logic        row_end;
        logic        frame_end;
    } win_t;

    typedef struct packed {
        logic        valid;
        logic [7:0]  pix;
        logic        flag;
        logic        row_end;
        logic        frame_end;
    } res_t;

    typedef struct packed {
        logic        enable;
        logic        mode;
        logic [15:0] thresh;
    } cfg_t;

endpackage

//--- design/box_apb_regs.sv
`timescale 1ns/1ps
`include "box_consts.svh"

module box_apb_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_psel,
    input  logic                i_penable,
    input  logic                i_pwrite,
    input  logic [11:0]         i_paddr,
    input  logic [31:0]         i_pwdata,
    output logic [31:0]         o_prdata,
    output logic                o_pready,
    output logic                o_pslverr,
    input  logic                i_frame_done,
    output box_pkg::cfg_t       o_cfg
);

    box_pkg::cfg_t cfg_q;
    logic [7:0]    frame_cnt;
    logic          access;
    logic          hit_ctrl;
    logic          hit_thresh;
    logic          hit_status;

    assign access     = i_psel && i_penable;
    assign hit_ctrl   = (i_paddr == `BOX_ADDR_CTRL);
    assign hit_thresh = (i_paddr == `BOX_ADDR_THRESH);
    assign hit_status = (i_paddr == `BOX_ADDR_STATUS);

    // No wait states
    assign o_pready  = 1'b1;
    assign o_pslverr = access && !(hit_ctrl || hit_thresh || hit_status);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register writes, STATUS is read only
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (access && i_pwrite) begin
            if (hit_ctrl) begin
                cfg_q.enable <= i_pwdata[0];
                cfg_q.mode   <= i_pwdata[1];
            end
            if (hit_thresh) begin
                cfg_q.thresh <= i_pwdata[15:0];
            end
        end
    end

    // Wraps at 256 frames
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (i_frame_done) begin
            frame_cnt <= frame_cnt + 8'd1;
        end
    end

    always_comb begin
        o_prdata = '0;
        if (hit_ctrl) begin
            o_prdata = {30'd0, cfg_q.mode, cfg_q.enable};
        end else if (hit_thresh) begin
            o_prdata = {16'd0, cfg_q.thresh};
        end else if (hit_status) begin
            o_prdata = {24'd0, frame_cnt};
        end
    end

    assign o_cfg = cfg_q;

    // Access phase only inside a selected transfer
    a_penable_needs_psel : assert property (
        @(posedge clk) disable iff (!rst_n) i_penable |-> i_psel
    );

endmodule

//--- design/col_sum_tree.sv
`timescale 1ns/1ps
`include "box_consts.svh"

module col_sum_tree (
    input  logic                clk,
    input  logic                rst_n,
    input  box_pkg::col_t       i_col,
    input  logic                i_enable,
    output box_pkg::colsum_t    o_colsum
);

    localparam int CENTRE = `BOX_WIN / 2;

    logic [4:0]                 vld_q;
    logic [`BOX_WIN-1:0][7:0]   pix_q;
    logic [5:0][8:0]            lvl1_q;
    logic [2:0][9:0]            lvl2_q;
    logic [1:0][10:0]           lvl3_q;
    logic [11:0]                lvl4_q;
    logic [1:0][7:0]            tail_q;
    logic [3:0][7:0]            centre_q;
    logic [11:0]                in_sum;

    // Valid shifts with the data by one bit per stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[3:0], i_col.valid && i_enable};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Adder tree 6 -> 3 -> 2 -> 1
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        pix_q <= i_col.pix;

        for (int i = 0; i < 6; i++) begin
            lvl1_q[i] <= 9'(pix_q[2*i]) + 9'(pix_q[2*i+1]);
        end

        for (int i = 0; i < 3; i++) begin
            lvl2_q[i] <= 10'(lvl1_q[2*i]) + 10'(lvl1_q[2*i+1]);
        end

        // Odd 13th pixel joins at the third level
        lvl3_q[0] <= 11'(lvl2_q[0]) + 11'(lvl2_q[1]);
        lvl3_q[1] <= 11'(lvl2_q[2]) + 11'(tail_q[1]);

        lvl4_q <= 12'(lvl3_q[0]) + 12'(lvl3_q[1]);
    end

    // Side delays for the odd pixel and the centre pixel
    always_ff @(posedge clk) begin
        tail_q[0]   <= pix_q[`BOX_WIN-1];
        tail_q[1]   <= tail_q[0];
        centre_q[0] <= pix_q[CENTRE];
        for (int i = 1; i < 4; i++) begin
            centre_q[i] <= centre_q[i-1];
        end
    end

    assign o_colsum = '{
        valid:  vld_q[4],
        sum:    lvl4_q,
        centre: centre_q[3]
    };

    // Flat sum of the incoming column
    always_comb begin
        in_sum = '0;
        for (int i = 0; i < `BOX_WIN; i++) begin
            in_sum = in_sum + 12'(i_col.pix[i]);
        end
    end

    // Fixed five cycle latency that keeps the gaps
    a_tree_latency : assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n, 5) |-> (o_colsum.valid == $past(i_col.valid && i_enable, 5))
    );

    // Tree result equals the plain sum of the same column
    a_tree_sum : assert property (
        @(posedge clk) disable iff (!rst_n)
        o_colsum.valid |-> (o_colsum.sum == $past(in_sum, 5))
    );

endmodule

//--- design/window_accum.sv
`timescale 1ns/1ps
`include "box_consts.svh"

module window_accum (
    input  logic                clk,
    input  logic                rst_n,
    input  box_pkg::colsum_t    i_colsum,
    output box_pkg::win_t       o_win
);

    localparam int STREAM_ROWS = `BOX_ROWS - `BOX_WIN + 1;
    localparam int COL_W       = $clog2(`BOX_COLS);
    localparam int ROW_W       = (STREAM_ROWS > 1) ? $clog2(STREAM_ROWS) : 1;
    localparam int CENTRE_LAG  = `BOX_WIN / 2;

    logic [COL_W-1:0]               col_cnt;
    logic [ROW_W-1:0]               row_cnt;
    logic                           last_col;
    logic                           last_row;
    logic [`BOX_WIN-1:0][11:0]      sum_hist;
    logic [CENTRE_LAG-1:0][7:0]     centre_hist;
    logic [15:0]                    acc_q;
    logic [15:0]                    acc_next;
    logic [7:0]                     centre_q;
    logic                           vld_q;
    logic                           row_end_q;
    logic                           frame_end_q;

    assign last_col = (col_cnt == COL_W'(`BOX_COLS - 1));
    assign last_row = (row_cnt == ROW_W'(STREAM_ROWS - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Column and stream row position
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_colsum.valid) begin
            if (last_col) begin
                col_cnt <= '0;
                row_cnt <= last_row ? '0 : row_cnt + ROW_W'(1);
            end else begin
                col_cnt <= col_cnt + COL_W'(1);
            end
        end
    end

    // Load at row start, grow until full, then slide
    always_comb begin
        if (col_cnt == '0) begin
            acc_next = 16'(i_colsum.sum);
        end else if (col_cnt < COL_W'(`BOX_WIN)) begin
            acc_next = acc_q + 16'(i_colsum.sum);
        end else begin
            acc_next = acc_q + 16'(i_colsum.sum) - 16'(sum_hist[`BOX_WIN-1]);
        end
    end

    // hist[k] holds column c-1-k
    always_ff @(posedge clk) begin
        if (i_colsum.valid) begin
            acc_q       <= acc_next;
            centre_q    <= centre_hist[CENTRE_LAG-1];
            sum_hist    <= {sum_hist[`BOX_WIN-2:0], i_colsum.sum};
            centre_hist <= {centre_hist[CENTRE_LAG-2:0], i_colsum.centre};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q       <= 1'b0;
            row_end_q   <= 1'b0;
            frame_end_q <= 1'b0;
        end else begin
            vld_q       <= i_colsum.valid && (col_cnt >= COL_W'(`BOX_WIN - 1));
            row_end_q   <= i_colsum.valid && last_col;
            frame_end_q <= i_colsum.valid && last_col && last_row;
        end
    end

    assign o_win = '{
        valid:     vld_q,
        sum:       acc_q,
        centre:    centre_q,
        row_end:   row_end_q,
        frame_end: frame_end_q
    };

    // Add and subtract must cancel, the sum stays inside one full window
    a_sum_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(i_colsum.valid) |-> (acc_q <= 16'(`BOX_AREA * 255))
    );

endmodule

//--- design/box_result.sv
`timescale 1ns/1ps
`include "box_consts.svh"

module box_result (
    input  logic                clk,
    input  logic                rst_n,
    input  box_pkg::win_t       i_win,
    input  box_pkg::cfg_t       i_cfg,
    output box_pkg::res_t       o_res
);

    logic [15:0]    centre_area;
    logic [16:0]    bound;
    logic           flag;
    logic [7:0]     pix_sel;
    logic           vld_q;
    logic [7:0]     pix_q;
    logic           flag_q;
    logic           row_end_q;
    logic           frame_end_q;

    // 255 * 169 still fits in 16 bits
    assign centre_area = 16'(i_win.centre) * 16'(`BOX_AREA);
    assign bound       = 17'(i_win.sum) + 17'(i_cfg.thresh);
    assign flag        = 17'(centre_area) > bound;

    // Binary output in mode 1, centre pass in mode 0
    always_comb begin
        if (!flag) begin
            pix_sel = 8'd0;
        end else if (i_cfg.mode) begin
            pix_sel = 8'hff;
        end else begin
            pix_sel = i_win.centre;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= i_win.valid;
        end
    end

    always_ff @(posedge clk) begin
        pix_q       <= pix_sel;
        flag_q      <= flag;
        row_end_q   <= i_win.row_end;
        frame_end_q <= i_win.frame_end;
    end

    assign o_res = '{
        valid:     vld_q,
        pix:       pix_q,
        flag:      flag_q,
        row_end:   row_end_q,
        frame_end: frame_end_q
    };

endmodule

//--- design/box_filter_top.sv
`timescale 1ns/1ps

module box_filter_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_psel,
    input  logic                i_penable,
    input  logic                i_pwrite,
    input  logic [11:0]         i_paddr,
    input  logic [31:0]         i_pwdata,
    output logic [31:0]         o_prdata,
    output logic                o_pready,
    output logic                o_pslverr,
    input  box_pkg::col_t       i_col,
    output box_pkg::res_t       o_res
);

    box_pkg::cfg_t      cfg;
    box_pkg::colsum_t   colsum;
    box_pkg::win_t      win;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    box_apb_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .i_frame_done (o_res.valid && o_res.frame_end),
        .o_cfg        (cfg)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel pipeline, 5 + 1 + 1 cycles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    col_sum_tree u_tree (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_col    (i_col),
        .i_enable (cfg.enable),
        .o_colsum (colsum)
    );

    window_accum u_accum (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_colsum (colsum),
        .o_win    (win)
    );

    box_result u_result (
        .clk   (clk),
        .rst_n (rst_n),
        .i_win (win),
        .i_cfg (cfg),
        .o_res (o_res)
    );

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst_n
);

    // Reset drops 1 ns after an edge, like the rest of the stimulus
    initial begin
        o_clk   = 1'b0;
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

//--- tb/box_filter_tb.sv
`timescale 1ns/1ps
`include "box_consts.svh"

module box_filter_tb;

    localparam int CLK_PERIOD_NS = 4;
    localparam int STREAM_ROWS   = `BOX_ROWS - `BOX_WIN + 1;
    localparam int N_TESTS       = 7;
    localparam int TOTAL_COLS    = N_TESTS * STREAM_ROWS * `BOX_COLS;
    localparam int WATCHDOG_NS   = TOTAL_COLS * 4 * CLK_PERIOD_NS + 20000;
    localparam logic [1:0] GAP_NONE   = 2'd0;
    localparam logic [1:0] GAP_RANDOM = 2'd1;
    localparam logic [1:0] GAP_FIXED  = 2'd2;

    typedef struct packed {
        logic        enable;
        logic        mode;
        logic [15:0] thresh;
        logic [1:0]  gaps;
    } test_t;

    typedef struct packed {
        logic [7:0]  pix;
        logic        flag;
        logic        row_end;
        logic        frame_end;
        logic [31:0] cyc;
    } expect_t;

    // Enable, mode, threshold, gap pattern
    test_t tests [N_TESTS] = '{
        '{1'b0, 1'b1, 16'h0000, GAP_NONE},
        '{1'b1, 1'b1, 16'h0000, GAP_NONE},
        '{1'b1, 1'b0, 16'h0000, GAP_RANDOM},
        '{1'b1, 1'b1, 16'hffff, GAP_RANDOM},
        '{1'b1, 1'b0, 16'hffff, GAP_NONE},
        '{1'b1, 1'b0, 16'd600,  GAP_FIXED},
        '{1'b1, 1'b1, 16'd2000, GAP_RANDOM}
    };

    logic               clk;
    logic               rst_n;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [11:0]        paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;
    box_pkg::col_t      col;
    box_pkg::res_t      res;
    logic [31:0]        lfsr_state;
    expect_t            exp_q[$];
    expect_t            mon_exp;
    int                 frames_done;
    int                 cyc = 0;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(4)) u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    box_filter_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr),
        .i_col     (col),
        .o_res     (res)
    );

    always @(posedge clk) cyc <= cyc + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH time=%0t signal=%s expected=0x%0h got=0x%0h",
                     $time, name, exp, got);
            $display("TEST FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("ERROR at %0t: %s", $time, what);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            check_true(waits < 16, "APB transfer never saw pready");
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_eq("o_pslverr", err, exp_err);
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] exp_data,
                              input logic exp_err, input string name);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_eq("o_pslverr", err, exp_err);
        if (!exp_err) begin
            check_eq(name, rdata, exp_data);
        end
    endtask

    task automatic check_registers();
        read_check(`BOX_ADDR_CTRL, 32'h0, 1'b0, "o_prdata(CTRL)");
        read_check(`BOX_ADDR_THRESH, 32'h0, 1'b0, "o_prdata(THRESH)");
        read_check(`BOX_ADDR_STATUS, 32'h0, 1'b0, "o_prdata(STATUS)");
        write_reg(`BOX_ADDR_CTRL, 32'h3, 1'b0);
        read_check(`BOX_ADDR_CTRL, 32'h3, 1'b0, "o_prdata(CTRL)");
        write_reg(`BOX_ADDR_CTRL, 32'hffff_fffe, 1'b0);
        read_check(`BOX_ADDR_CTRL, 32'h2, 1'b0, "o_prdata(CTRL)");
        write_reg(`BOX_ADDR_THRESH, 32'habcd_1234, 1'b0);
        read_check(`BOX_ADDR_THRESH, 32'h1234, 1'b0, "o_prdata(THRESH)");
        // STATUS ignores writes and unmapped addresses flag an error
        write_reg(`BOX_ADDR_STATUS, 32'h55, 1'b0);
        read_check(`BOX_ADDR_STATUS, 32'h0, 1'b0, "o_prdata(STATUS)");
        write_reg(12'h00c, 32'h1, 1'b1);
        read_check(12'h010, 32'h0, 1'b1, "o_prdata(unmapped)");
        read_check(`BOX_ADDR_THRESH, 32'h1234, 1'b0, "o_prdata(THRESH)");
        write_reg(`BOX_ADDR_CTRL, 32'h0, 1'b0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel stream and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic insert_gap(input logic [1:0] kind, input int n);
        logic [31:0] r;
        int          idle;
        idle = 0;
        if (kind == GAP_RANDOM) begin
            draw_bits(2, r);
            idle = r[1] ? 0 : int'(r[0]) + 1;
        end else if (kind == GAP_FIXED) begin
            idle = (n % 3 == 2) ? 1 : 0;
        end
        repeat (idle) begin
            @(posedge clk);
            #1;
            col.valid = 1'b0;
            col.pix   = '1;
        end
    endtask

    task automatic run_test(input test_t t);
        int             csum [`BOX_COLS];
        logic [7:0]     ctr [`BOX_COLS];
        box_pkg::col_t  next_col;
        logic [31:0]    r;
        int             wsum;
        int             centre;
        expect_t        e;
        int             n;
        n = 0;
        write_reg(`BOX_ADDR_THRESH, {16'd0, t.thresh}, 1'b0);
        write_reg(`BOX_ADDR_CTRL, {30'd0, t.mode, t.enable}, 1'b0);
        for (int row = 0; row < STREAM_ROWS; row++) begin
            for (int c = 0; c < `BOX_COLS; c++) begin
                insert_gap(t.gaps, n);
                n++;
                next_col.valid = 1'b1;
                csum[c] = 0;
                for (int k = 0; k < `BOX_WIN; k++) begin
                    draw_bits(8, r);
                    next_col.pix[k] = r[7:0];
                    csum[c] += r[7:0];
                end
                ctr[c] = next_col.pix[`BOX_WIN / 2];
                @(posedge clk);
                #1;
                col = next_col;
                // Full window of the last 13 columns with the centre 6 columns back
                if (t.enable && c >= `BOX_WIN - 1) begin
                    wsum = 0;
                    for (int k = c - `BOX_WIN + 1; k <= c; k++) begin
                        wsum += csum[k];
                    end
                    centre      = ctr[c - `BOX_WIN / 2];
                    e.flag      = (centre * `BOX_AREA) > (wsum + int'(t.thresh));
                    e.pix       = !e.flag ? 8'd0 : (t.mode ? 8'hff : 8'(centre));
                    e.row_end   = (c == `BOX_COLS - 1);
                    e.frame_end = (c == `BOX_COLS - 1) && (row == STREAM_ROWS - 1);
                    e.cyc       = cyc;
                    exp_q.push_back(e);
                end
            end
        end
        @(posedge clk);
        #1;
        col.valid = 1'b0;
        if (t.enable) begin
            while (exp_q.size() != 0) @(posedge clk);
            frames_done++;
        end else begin
            repeat (12) @(posedge clk);
        end
        read_check(`BOX_ADDR_STATUS, 32'(frames_done), 1'b0, "o_prdata(STATUS)");
    endtask

    // Results come in order with a fixed latency of 7
    always @(negedge clk) begin
        if (rst_n && res.valid) begin
            check_true(exp_q.size() != 0, "o_res.valid high while no result was expected");
            mon_exp = exp_q.pop_front();
            check_eq("o_res.flag", res.flag, mon_exp.flag);
            check_eq("o_res.pix", res.pix, mon_exp.pix);
            check_eq("o_res.row_end", res.row_end, mon_exp.row_end);
            check_eq("o_res.frame_end", res.frame_end, mon_exp.frame_end);
            check_eq("o_res latency", cyc - mon_exp.cyc, 32'd7);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        col         = '0;
        lfsr_state  = 32'hb4d3;
        frames_done = 0;
        wait (rst_n);
        check_registers();
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(tests[t]);
        end
        repeat (4) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+design
design/box_pkg.sv
design/box_apb_regs.sv
design/col_sum_tree.sv
design/window_accum.sv
design/box_result.sv
design/box_filter_top.sv
tb/tb_clk_gen.sv
tb/box_filter_tb.sv
